//--- verilog/sdCard_config.svh
// Constants for the SPI-mode SD card target.
// SDSC only: arguments are byte addresses and the memory is far smaller than a card.
// SD_MEM_BYTES must equal 2**SD_ADR_W. SD_MAX_BLOCK must fit the 10-bit block length.
// The byte counts below must be at least 1.
`ifndef SD_CARD_CONFIG_SVH
`define SD_CARD_CONFIG_SVH

// memory
`define SD_MEM_BYTES    1024
`define SD_ADR_W        10
`define SD_MAX_BLOCK    512

// gaps on miso, in whole bytes
`define SD_NCR_BYTES    1          // 0xFF before every response
`define SD_NAC_BYTES    1          // 0xFF between R1 and the start token
`define SD_BUSY_BYTES   4          // zero bytes after the data response

// tokens and fixed words
`define SD_START_TOKEN  8'hFE
`define SD_CRC_STUB     16'hAAAA   // read CRC is not computed
`define SD_DATA_ACCEPT  8'h05
`define SD_OCR          32'h80FF8000
`define SD_CARD_VHS     4'h1       // 2.7-3.6 V

`endif

//--- verilog/sdCardPkg.sv
// Types shared by the command decoder, the response transmitter and the testbench.
// The frame holds everything after the start bit, so it is 47 bits wide.
package sdCardPkg;

   // command argument, seen as an address or as the CMD8 fields
   typedef union packed {
      logic [31:0] adr;             // byte address, or block length for CMD16
      struct packed {
         logic [19:0] rsvd;
         logic [3:0]  vhs;          // supply voltage the host offers
         logic [7:0]  pattern;      // echoed back in R7
      } cmd8;
   } sdArgT;

   typedef struct packed {
      logic       dir;              // 1 = host to card
      logic [5:0] index;
      sdArgT      arg;
      logic [6:0] crc;              // not checked
      logic       endBit;
   } sdCmdFrameT;

   typedef enum logic [2:0] {
      kindR1,
      kindR7,                       // R1 + voltage echo
      kindR3,                       // R1 + OCR
      kindRdBlk,                    // R1 + token, block and CRC
      kindDataResp                  // data response + busy after a write
   } sdRespKindT;

   typedef struct packed {
      logic zero;                   // always 0, host hunts for it
      logic paramErr;
      logic adrErr;
      logic eraseSeqErr;
      logic crcErr;
      logic illegalCmd;
      logic eraseReset;
      logic idle;
   } sdR1T;

endpackage

//--- verilog/sdCmdDecode.sv
// Command side of the card: frames 48-bit commands on mosi, holds the init state
// and block length, and stores single write blocks through a Wishbone master port.
// mosi is ignored while ncs is high and while the transmitter is busy.
// The write token is found with a sliding 8-bit window, data bytes align on it.
`timescale 1ns/100ps
`include "sdCard_config.svh"

module sdCmdDecode (
   input  logic                         sclk,
   input  logic                         rstn,
   input  logic                         ncs,
   input  logic                         mosi,
   input  logic                         txBusy,
   output logic                         wbWrCyc,
   output logic                         wbWrStb,
   output logic [`SD_ADR_W-1:0]         wbWrAdr,
   output logic [7:0]                   wbWrDat,
   input  logic                         wbWrAck,
   output logic                         respStart,
   output sdCardPkg::sdRespKindT        respKind,
   output sdCardPkg::sdR1T              respR1,
   output logic [31:0]                  respWord,
   output logic [`SD_ADR_W-1:0]         rdAdr,
   output logic [9:0]                   blkLen
);

   typedef enum logic [3:0] {
      stHunt, stDir, stFrame, stDecode, stRespWait, stWrWait, stTokHunt, stWrData, stWrCrc
   } stateT;

   stateT                  state;
   sdCardPkg::sdCmdFrameT  frame;
   sdCardPkg::sdR1T        r1Next;
   sdCardPkg::sdRespKindT  kindNext;
   logic [5:0]             bitCnt;
   logic [9:0]             byteCnt;
   logic [7:0]             byteSh;      // write token window and data bytes
   logic                   initDone;
   logic                   appCmd;      // last command was CMD55
   logic                   badLen;
   logic                   outOfRange;
   logic                   wrOk;
   logic                   crcDone;
   logic [31:0]            cmd8Echo;

   assign badLen     = (frame.arg.adr == 32'd0) || (frame.arg.adr > `SD_MAX_BLOCK);
   assign outOfRange = ({1'b0, frame.arg.adr} + 33'(blkLen)) > 33'(`SD_MEM_BYTES);
   assign wrOk       = !appCmd && (frame.index == 6'd24) && (r1Next == '0);
   assign crcDone    = (state == stWrCrc) && (bitCnt == 6'd15);
   // voltage field comes back only when the card supports it
   assign cmd8Echo   = {20'h0,
                        (frame.arg.cmd8.vhs == `SD_CARD_VHS) ? frame.arg.cmd8.vhs : 4'h0,
                        frame.arg.cmd8.pattern};

   // R1 and response kind of the frame just received
   always_comb begin
      r1Next = '0;
      r1Next.idle = ~initDone;
      kindNext = sdCardPkg::kindR1;
      if (appCmd) begin
         if (frame.index == 6'd41)
            r1Next.idle = 1'b0;                   // ACMD41 ends init
         else
            r1Next.illegalCmd = 1'b1;             // only ACMD41 is known
      end else begin
         case (frame.index)
            6'd0:  r1Next.idle = 1'b1;            // card drops back to idle
            6'd8:  kindNext = sdCardPkg::kindR7;
            6'd55: r1Next.illegalCmd = 1'b0;
            6'd58: kindNext = sdCardPkg::kindR3;
            6'd16, 6'd17, 6'd24: begin
               if (!initDone)
                  r1Next.illegalCmd = 1'b1;
               else if (frame.index == 6'd16)
                  r1Next.paramErr = badLen;
               else if (outOfRange)
                  r1Next.adrErr = 1'b1;           // no data follows
               else if (frame.index == 6'd17)
                  kindNext = sdCardPkg::kindRdBlk;
            end
            default: r1Next.illegalCmd = 1'b1;
         endcase
      end
   end

   always_ff @(posedge sclk) begin
      if (!rstn) begin
         state     <= stHunt;
         bitCnt    <= '0;
         byteCnt   <= '0;
         initDone  <= 1'b0;
         appCmd    <= 1'b0;
         blkLen    <= 10'(`SD_MAX_BLOCK);
         respStart <= 1'b0;
         wbWrCyc   <= 1'b0;
         wbWrStb   <= 1'b0;
      end else begin
         respStart <= 1'b0;
         if (wbWrStb && wbWrAck) begin
            wbWrStb <= 1'b0;
            wbWrCyc <= 1'b0;
         end
         if (!ncs) begin
            bitCnt <= bitCnt + 6'd1;
            case (state)
               stHunt: if (!mosi) state <= stDir;     // start bit
               stDir: begin
                  if (mosi) begin                     // direction bit, frame follows
                     state  <= stFrame;
                     bitCnt <= '0;
                  end
               end
               stFrame: if (bitCnt == 6'd45) state <= stDecode;
               stDecode: begin
                  respStart <= 1'b1;
                  appCmd    <= !appCmd && (frame.index == 6'd55);
                  if (appCmd && frame.index == 6'd41)
                     initDone <= 1'b1;
                  if (!appCmd && frame.index == 6'd0)
                     initDone <= 1'b0;
                  if (!appCmd && frame.index == 6'd16 && r1Next == '0)
                     blkLen <= frame.arg.adr[9:0];
                  state <= wrOk ? stWrWait : stRespWait;
               end
               // respStart still high means txBusy has not risen yet
               stRespWait, stWrWait: begin
                  if (!respStart && !txBusy)
                     state <= (state == stWrWait) ? stTokHunt : stHunt;
               end
               stTokHunt: begin
                  if ({byteSh[6:0], mosi} == `SD_START_TOKEN) begin
                     state   <= stWrData;
                     bitCnt  <= '0;
                     byteCnt <= '0;
                  end
               end
               stWrData: begin
                  if (bitCnt[2:0] == 3'd7) begin
                     wbWrCyc <= 1'b1;
                     wbWrStb <= 1'b1;
                     byteCnt <= byteCnt + 10'd1;
                     if (byteCnt == blkLen - 10'd1) begin
                        state  <= stWrCrc;
                        bitCnt <= '0;
                     end
                  end
               end
               stWrCrc: begin
                  if (crcDone) begin                  // CRC16 skipped
                     respStart <= 1'b1;
                     state     <= stRespWait;
                  end
               end
               default: state <= stHunt;
            endcase
         end
      end
   end

   always_ff @(posedge sclk) begin
      if (wbWrStb && wbWrAck)
         wbWrAdr <= wbWrAdr + 1'b1;
      if (!ncs) begin
         frame  <= {frame[45:0], mosi};
         byteSh <= (state == stTokHunt || state == stWrData) ? {byteSh[6:0], mosi} : 8'hFF;
         if (state == stWrData && bitCnt[2:0] == 3'd7)
            wbWrDat <= {byteSh[6:0], mosi};
         if (state == stDecode) begin
            respR1   <= r1Next;
            respKind <= kindNext;
            respWord <= (frame.index == 6'd58) ? `SD_OCR : cmd8Echo;
            rdAdr    <= frame.arg.adr[`SD_ADR_W-1:0];
            wbWrAdr  <= frame.arg.adr[`SD_ADR_W-1:0];
         end
         if (crcDone)
            respKind <= sdCardPkg::kindDataResp;
      end
   end

   // CMD16 must never load a length the transmitter cannot count
   aBlkLenRange: assert property (@(posedge sclk) disable iff (!rstn)
      blkLen != 10'd0 && blkLen <= 10'(`SD_MAX_BLOCK));

endmodule

//--- verilog/sdBlockMem.sv
// Card contents: a byte array with one Wishbone classic write port and one read port.
// Each byte powers up as its address plus 3, modulo 256, and nothing clears it.
// Ack follows stb by one cycle and lasts one cycle, so a held stb gives one transfer.
`timescale 1ns/100ps
`include "sdCard_config.svh"

module sdBlockMem (
   input  logic                  sclk,
   input  logic                  wbWrCyc,
   input  logic                  wbWrStb,
   input  logic [`SD_ADR_W-1:0]  wbWrAdr,
   input  logic [7:0]            wbWrDat,
   output logic                  wbWrAck,
   input  logic                  wbRdCyc,
   input  logic                  wbRdStb,
   input  logic [`SD_ADR_W-1:0]  wbRdAdr,
   output logic [7:0]            wbRdDat,
   output logic                  wbRdAck
);

   logic [7:0] mem [0:`SD_MEM_BYTES-1];

   initial begin
      for (int i = 0; i < `SD_MEM_BYTES; i++)
         mem[i] = 8'(i + 3);
   end

   always_ff @(posedge sclk) begin
      if (wbWrCyc && wbWrStb && !wbWrAck)
         mem[wbWrAdr] <= wbWrDat;
      wbWrAck <= wbWrCyc && wbWrStb && !wbWrAck;    // no second ack on a held stb
      wbRdAck <= wbRdCyc && wbRdStb && !wbRdAck;
      wbRdDat <= mem[wbRdAdr];
   end

   aWrStbInCyc: assert property (@(posedge sclk) $rose(wbWrStb) |-> wbWrCyc);
   aRdStbInCyc: assert property (@(posedge sclk) $rose(wbRdStb) |-> wbRdCyc);

endmodule

//--- verilog/sdRespTx.sv
// Response side of the card: shifts whole bytes out on miso, MSB first, on rising sclk.
// Sequences: NCR gap, R1, then the R7/R3 word or the NAC gap, token, block and CRC stub;
// or the data response followed by busy zeros. The sequence pauses while ncs is high.
// Block bytes come from the read port one byte ahead of the shifter.
`timescale 1ns/100ps
`include "sdCard_config.svh"

module sdRespTx (
   input  logic                         sclk,
   input  logic                         rstn,
   input  logic                         ncs,
   input  logic                         respStart,
   input  sdCardPkg::sdRespKindT        respKind,
   input  sdCardPkg::sdR1T              respR1,
   input  logic [31:0]                  respWord,
   input  logic [`SD_ADR_W-1:0]         rdAdr,
   input  logic [9:0]                   blkLen,
   output logic                         txBusy,
   output logic                         miso,
   output logic                         wbRdCyc,
   output logic                         wbRdStb,
   output logic [`SD_ADR_W-1:0]         wbRdAdr,
   input  logic [7:0]                   wbRdDat,
   input  logic                         wbRdAck
);

   typedef enum logic [3:0] {
      phIdle, phNcr, phR1, phTail, phNac, phToken, phData, phCrc, phDresp, phBusy
   } phaseT;

   localparam logic [15:0] crcStub = `SD_CRC_STUB;

   phaseT       phase;
   phaseT       nextPhase;
   logic [2:0]  bitCnt;
   logic [9:0]  byteCnt;
   logic [9:0]  lastCnt;        // byteCnt of the last byte in this phase
   logic [7:0]  curByte;
   logic [6:0]  shReg;
   logic [7:0]  dataBuf;        // next block byte
   logic        misoReg;
   logic        fetchGo;

   always_comb begin
      curByte   = 8'hFF;        // gaps
      lastCnt   = '0;
      nextPhase = phIdle;
      case (phase)
         phNcr: begin
            lastCnt   = 10'(`SD_NCR_BYTES - 1);
            nextPhase = phR1;
         end
         phR1: begin
            curByte = respR1;
            if (respKind == sdCardPkg::kindR7 || respKind == sdCardPkg::kindR3)
               nextPhase = phTail;
            else if (respKind == sdCardPkg::kindRdBlk)
               nextPhase = phNac;
         end
         phTail: begin
            curByte = respWord[31 - 8 * byteCnt[1:0] -: 8];
            lastCnt = 10'd3;
         end
         phNac: begin
            lastCnt   = 10'(`SD_NAC_BYTES - 1);
            nextPhase = phToken;
         end
         phToken: begin
            curByte   = `SD_START_TOKEN;
            nextPhase = phData;
         end
         phData: begin
            curByte   = dataBuf;
            lastCnt   = blkLen - 10'd1;
            nextPhase = phCrc;
         end
         phCrc: begin
            curByte = byteCnt[0] ? crcStub[7:0] : crcStub[15:8];
            lastCnt = 10'd1;
         end
         phDresp: begin
            curByte   = `SD_DATA_ACCEPT;
            nextPhase = phBusy;
         end
         phBusy: begin
            curByte = 8'h00;
            lastCnt = 10'(`SD_BUSY_BYTES - 1);
         end
         default: curByte = 8'hFF;
      endcase
   end

   // byte 0 is fetched under the token, byte i+1 while byte i shifts out
   assign fetchGo = !ncs && (bitCnt == 3'd0) &&
                    (phase == phToken || (phase == phData && byteCnt != lastCnt));
   assign txBusy  = (phase != phIdle);
   assign miso    = misoReg | ncs;

   always_ff @(posedge sclk) begin
      if (!rstn) begin
         phase   <= phIdle;
         bitCnt  <= '0;
         byteCnt <= '0;
         misoReg <= 1'b1;
         wbRdCyc <= 1'b0;
         wbRdStb <= 1'b0;
      end else begin
         if (wbRdStb && wbRdAck) begin
            wbRdCyc <= 1'b0;
            wbRdStb <= 1'b0;
         end
         if (fetchGo) begin
            wbRdCyc <= 1'b1;
            wbRdStb <= 1'b1;
         end
         if (phase == phIdle) begin
            misoReg <= 1'b1;
            bitCnt  <= '0;
            byteCnt <= '0;
            if (respStart)
               phase <= (respKind == sdCardPkg::kindDataResp) ? phDresp : phNcr;
         end else if (!ncs) begin
            misoReg <= (bitCnt == 3'd0) ? curByte[7] : shReg[6];
            bitCnt  <= bitCnt + 3'd1;
            if (bitCnt == 3'd7) begin                     // last bit of the byte
               byteCnt <= (byteCnt == lastCnt) ? 10'd0 : byteCnt + 10'd1;
               if (byteCnt == lastCnt)
                  phase <= nextPhase;
            end
         end
      end
   end

   always_ff @(posedge sclk) begin
      if (!ncs)
         shReg <= (bitCnt == 3'd0) ? curByte[6:0] : {shReg[5:0], 1'b1};
      if (wbRdStb && wbRdAck)
         dataBuf <= wbRdDat;
      if (fetchGo)
         wbRdAdr <= (phase == phToken) ? rdAdr : wbRdAdr + 1'b1;
   end

   // the decoder must wait for the previous response to finish
   aNoStartWhenBusy: assert property (@(posedge sclk) disable iff (!rstn)
      respStart |-> !txBusy);

endmodule

//--- verilog/spiSdCard.sv
// SPI-mode SD card target, SDSC with byte addressing, single clock domain on sclk.
// Commands kept: CMD0, 8, 16, 17, 24, 55, 58 and ACMD41. No CRC checks.
// miso is driven at all times and sits high while ncs is high.
`timescale 1ns/100ps
`include "sdCard_config.svh"

module spiSdCard (
   input  logic sclk,
   input  logic rstn,
   input  logic ncs,
   input  logic mosi,
   output logic miso
);

   logic                        txBusy;
   logic                        respStart;
   sdCardPkg::sdRespKindT       respKind;
   sdCardPkg::sdR1T             respR1;
   logic [31:0]                 respWord;
   logic [`SD_ADR_W-1:0]        rdAdr;
   logic [9:0]                  blkLen;
   // write port, decoder to memory
   logic                        wbWrCyc;
   logic                        wbWrStb;
   logic                        wbWrAck;
   logic [`SD_ADR_W-1:0]        wbWrAdr;
   logic [7:0]                  wbWrDat;
   // read port, transmitter to memory
   logic                        wbRdCyc;
   logic                        wbRdStb;
   logic                        wbRdAck;
   logic [`SD_ADR_W-1:0]        wbRdAdr;
   logic [7:0]                  wbRdDat;

   sdCmdDecode uCmdDecode (
      .sclk, .rstn, .ncs, .mosi, .txBusy,
      .wbWrCyc, .wbWrStb, .wbWrAdr, .wbWrDat, .wbWrAck,
      .respStart, .respKind, .respR1, .respWord, .rdAdr, .blkLen
   );

   sdBlockMem uBlockMem (
      .sclk,
      .wbWrCyc, .wbWrStb, .wbWrAdr, .wbWrDat, .wbWrAck,
      .wbRdCyc, .wbRdStb, .wbRdAdr, .wbRdDat, .wbRdAck
   );

   sdRespTx uRespTx (
      .sclk, .rstn, .ncs,
      .respStart, .respKind, .respR1, .respWord, .rdAdr, .blkLen,
      .txBusy, .miso,
      .wbRdCyc, .wbRdStb, .wbRdAdr, .wbRdDat, .wbRdAck
   );

endmodule

//--- bench/tbSpiSdCard.sv
// Testbench for the SPI SD card target. Steps come from bench/sdHostInput.txt.
// The host clocks mosi 1 ns after each rising edge and samples miso at the same point.
// Read data is predicted from a local copy of the card memory, updated on writes.
`timescale 1ns/100ps
`include "sdCard_config.svh"

module tbSpiSdCard;

   localparam int maxSteps = 32;
   localparam int huntBits = 8 * (`SD_NCR_BYTES + 2);    // R1 must start within this

   logic sclk = 1'b0;
   logic rstn;
   logic ncs;
   logic mosi;
   logic miso;

   logic [31:0] stepMem [0:maxSteps*5-1];
   logic [7:0]  model [0:`SD_MEM_BYTES-1];               // expected card contents
   logic [9:0]  hostBlkLen;
   int          errCount = 0;
   int          testCount = 0;
   int          badTests = 0;
   int          cycleCnt = 0;
   int          cycleLimit = 0;
   int          nSteps;
   int          totalBytes;

   spiSdCard DUT (.sclk, .rstn, .ncs, .mosi, .miso);

   always #2 sclk = ~sclk;

   always @(posedge sclk) begin
      cycleCnt <= cycleCnt + 1;
      if (cycleLimit > 0 && cycleCnt >= cycleLimit) begin
         $display("timeout: run stopped after %0d clock cycles", cycleCnt);
         $display("tests failed");
         $finish;
      end
   end

   function automatic logic [31:0] lcgNext(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // rough upper bound of bytes clocked by one step
   function automatic int stepBytes(input logic [31:0] code, input logic [31:0] r1);
      int n;
      n = 6 + `SD_NCR_BYTES + 2 + 2;
      if (code == 2)
         n += 4;
      else if (code == 3)
         n += (r1 == 0) ? (`SD_NAC_BYTES + 1 + `SD_MAX_BLOCK + 2) : 4;
      else if (code == 4)
         n += 2 + `SD_MAX_BLOCK + 2 + 2 + `SD_BUSY_BYTES + 4;
      return n;
   endfunction

   task automatic checkR1(input string sig, input sdCardPkg::sdR1T got,
                          input sdCardPkg::sdR1T exp);
      if (got !== exp) begin
         $display("FAILED %s: got 0x%h, expected 0x%h", sig, got, exp);
         errCount++;
      end
   endtask

   task automatic checkWord(input string sig, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("FAILED %s: got 0x%h, expected 0x%h", sig, got, exp);
         errCount++;
      end
   endtask

   task automatic checkByte(input string sig, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         $display("FAILED %s: got 0x%h, expected 0x%h", sig, got, exp);
         errCount++;
      end
   endtask

   task automatic xferBit(input logic txBit, output logic rxBit);
      @(posedge sclk);
      #1;
      mosi  = txBit;
      rxBit = miso;       // value the card put out on this edge
   endtask

   task automatic xferByte(input logic [7:0] txb, output logic [7:0] rxb);
      logic r;
      int   i;
      for (i = 7; i >= 0; i--) begin
         xferBit(txb[i], r);
         rxb[i] = r;
      end
   endtask

   task automatic sendFrame(input logic [5:0] index, input logic [31:0] arg);
      sdCardPkg::sdCmdFrameT frame;
      logic [47:0]           bits;
      logic                  unused;
      int                    i;
      frame.dir     = 1'b1;
      frame.index   = index;
      frame.arg.adr = arg;
      frame.crc     = 7'h7F;            // card does not check it
      frame.endBit  = 1'b1;
      bits = {1'b0, frame};
      for (i = 47; i >= 0; i--)
         xferBit(bits[i], unused);
   endtask

   // wait for the first zero bit on miso, then take the rest of that byte
   task automatic huntByte(input int maxBits, output logic [7:0] b, output logic found);
      logic r;
      int   n;
      int   i;
      r = 1'b1;
      n = 0;
      b = 8'hFF;
      while (r && n < maxBits) begin
         xferBit(1'b1, r);
         n++;
      end
      found = !r;
      if (found) begin
         b[7] = 1'b0;
         for (i = 6; i >= 0; i--) begin
            xferBit(1'b1, r);
            b[i] = r;
         end
      end
   endtask

   task automatic readBlock(input logic [31:0] adr, input int len);
      logic [7:0]  b;
      logic [15:0] crc;
      int          tries;
      int          i;
      tries = 0;
      b = 8'hFF;
      while (b != `SD_START_TOKEN && tries < `SD_NAC_BYTES + 4) begin
         xferByte(8'hFF, b);
         tries++;
      end
      if (b != `SD_START_TOKEN) begin
         $display("error: no start token within %0d bytes after R1", tries);
         errCount++;
      end else begin
         for (i = 0; i < len; i++) begin
            xferByte(8'hFF, b);
            checkByte($sformatf("read data[%0d]", i), b, model[(int'(adr) + i) % `SD_MEM_BYTES]);
         end
         xferByte(8'hFF, crc[15:8]);
         xferByte(8'hFF, crc[7:0]);
         checkWord("read CRC", {16'h0, crc}, {16'h0, `SD_CRC_STUB});
      end
   endtask

   task automatic expectNoToken();
      logic [7:0] b;
      int         i;
      for (i = 0; i < 4; i++) begin
         xferByte(8'hFF, b);
         if (b == `SD_START_TOKEN) begin
            $display("error: start token sent although R1 reported an error");
            errCount++;
         end
      end
   endtask

   task automatic writeBlock(input logic [31:0] adr, input int len, input logic [31:0] seed);
      logic [31:0] lcg;
      logic [7:0]  b;
      logic [7:0]  unused;
      logic        found;
      int          i;
      lcg = seed;
      xferByte(8'hFF, unused);                        // gap before the token
      xferByte(`SD_START_TOKEN, unused);
      for (i = 0; i < len; i++) begin
         lcg = lcgNext(lcg);
         model[(int'(adr) + i) % `SD_MEM_BYTES] = lcg[23:16];
         xferByte(lcg[23:16], unused);
      end
      xferByte(8'hFF, unused);                        // CRC16, ignored by the card
      xferByte(8'hFF, unused);
      huntByte(16, b, found);
      if (!found) begin
         $display("error: no data response after the write block");
         errCount++;
      end else begin
         checkByte("data response", b, `SD_DATA_ACCEPT);
         i = 0;
         b = 8'h00;
         while (b == 8'h00 && i < `SD_BUSY_BYTES + 4) begin
            xferByte(8'hFF, b);
            i++;
         end
         if (b == 8'h00) begin
            $display("error: card still busy after %0d bytes", i);
            errCount++;
         end
      end
   endtask

   task automatic runStep(input int num, input logic [31:0] code, input logic [31:0] idx,
                          input logic [31:0] arg, input logic [31:0] expR1,
                          input logic [31:0] extra);
      sdCardPkg::sdR1T r1;
      logic [7:0]      b;
      logic [31:0]     word;
      logic            found;
      int              errBefore;
      errBefore = errCount;
      @(posedge sclk);
      #1 ncs = 1'b0;
      sendFrame(idx[5:0], arg);
      huntByte(huntBits, b, found);
      r1 = b;
      if (!found) begin
         $display("error: no R1 from the card within %0d clocks", huntBits);
         errCount++;
      end else begin
         checkR1("R1", r1, expR1[7:0]);
         case (code)
            1: if (idx == 16 && expR1 == 0) hostBlkLen = arg[9:0];
            2: begin
               xferByte(8'hFF, word[31:24]);
               xferByte(8'hFF, word[23:16]);
               xferByte(8'hFF, word[15:8]);
               xferByte(8'hFF, word[7:0]);
               checkWord((idx == 58) ? "OCR" : "R7 echo", word, extra);
            end
            3: if (expR1 == 0) readBlock(arg, hostBlkLen); else expectNoToken();
            4: if (expR1 == 0) writeBlock(arg, hostBlkLen, extra);
            default: ;
         endcase
      end
      xferByte(8'hFF, b);                             // let the decoder return to hunting
      xferByte(8'hFF, b);
      ncs = 1'b1;
      testCount++;
      if (errCount != errBefore)
         badTests++;
      $display("test %0d CMD%0d arg 0x%h: %s", num, idx, arg,
               (errCount == errBefore) ? "ok" : "errors");
   endtask

   initial begin
      int i;
      rstn = 1'b0;
      ncs  = 1'b1;
      mosi = 1'b1;
      hostBlkLen = 10'(`SD_MAX_BLOCK);
      for (i = 0; i < maxSteps * 5; i++)
         stepMem[i] = '0;
      for (i = 0; i < `SD_MEM_BYTES; i++)
         model[i] = 8'(i + 3);
      $readmemh("bench/sdHostInput.txt", stepMem);
      nSteps = 0;
      totalBytes = 0;
      while (nSteps < maxSteps && stepMem[nSteps * 5] != 0) begin
         totalBytes += stepBytes(stepMem[nSteps * 5], stepMem[nSteps * 5 + 3]);
         nSteps++;
      end
      cycleLimit = totalBytes * 8 * 2 + 200;
      if (nSteps == 0) begin
         $display("error: no test steps read from the input file");
         errCount++;
      end
      repeat (16) @(posedge sclk);
      #1 rstn = 1'b1;
      repeat (4) @(posedge sclk);
      for (i = 0; i < nSteps; i++)
         runStep(i + 1, stepMem[i*5], stepMem[i*5+1], stepMem[i*5+2], stepMem[i*5+3],
                 stepMem[i*5+4]);
      $display("summary: %0d tests run, %0d ok, %0d with errors, %0d check errors",
               testCount, testCount - badTests, badTests, errCount);
      if (errCount == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

//--- all.f
+incdir+verilog
verilog/sdCardPkg.sv
verilog/sdCmdDecode.sv
verilog/sdBlockMem.sv
verilog/sdRespTx.sv
verilog/spiSdCard.sv
bench/tbSpiSdCard.sv

//--- run.sh
#!/bin/sh
# compile and run the SPI SD card testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
   -f all.f --top-module tbSpiSdCard -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
   echo "verilator build did not complete"
   exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^all tests passed$" sim.log; then
   exit 0
fi
exit 1

//--- bench/sdHostInput.txt
// columns: step code, command index, argument, expected R1, expected word or write seed
// step codes: 1 R1 only, 2 R1 plus 32-bit word, 3 block read, 4 block write, 0 end
1 00 00000000 01 00000000
3 11 00000000 05 00000000
2 08 000001AA 01 000001AA
2 08 000002AA 01 000000AA
1 37 00000000 01 00000000
1 29 40000000 00 00000000
2 3A 00000000 00 80FF8000
1 05 00000000 04 00000000
1 37 00000000 00 00000000
1 06 00000000 04 00000000
1 10 00000010 00 00000000
3 11 00000064 00 00000000
4 18 000000C8 00 00010E2B
3 11 000000C8 00 00000000
3 11 000003FC 20 00000000
1 10 00000258 40 00000000
3 11 00000064 00 00000000
0 00 00000000 00 00000000
